// ==== src.f ====
decode_pkg.sv
inst_classifier.sv
imm_gen.sv
uop_select.sv
reg_use.sv
decode_stage.sv
tb_clock_gen.sv
tb_decode_stage.sv

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int CLK_PERIOD  = 8;
    localparam int RST_CYCLES  = 8;
    localparam int NUM_ENTRIES = 24;
    // two cycles per entry, plus reset and some slack
    localparam int TIMEOUT_NS  = (2 * NUM_ENTRIES + RST_CYCLES + 20) * CLK_PERIOD;

    typedef struct packed {
        inst_t     inst;
        logic      unk;
        dec_info_t exp;
    } vector_t;

    logic      clk;
    logic      rst_n;
    logic      valid;
    inst_t     inst;
    logic      out_valid;
    dec_info_t decinfo;
    logic      unknown_inst;

    vector_t   vectors [NUM_ENTRIES];
    int        n_vectors;

    tb_clock_gen u_clk (
        .o_clk (clk)
    );

    decode_stage UUT (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_valid        (valid),
        .i_inst         (inst),
        .o_valid        (out_valid),
        .o_decinfo      (decinfo),
        .o_unknown_inst (unknown_inst)
    );

    task automatic add_entry(input inst_t i_word, input logic unk, input exec_unit_e unit,
                             input micro_op_t uop, input disp_que_e dq, input issue_que_e iq,
                             input logic use_imm, input logic is_store, input imm20_t imm,
                             input reg_idx_t rd, input logic rd_wen,
                             input reg_idx_t rs1, input logic rs1_ren,
                             input reg_idx_t rs2, input logic rs2_ren,
                             input logic ismv, input logic isnop);
        vector_t v;
        v = '0;
        v.inst          = i_word;
        v.unk           = unk;
        v.exp.exec_unit = unit;
        v.exp.micro_op  = uop;
        v.exp.disp_que  = dq;
        v.exp.issue_que = iq;
        v.exp.use_imm   = use_imm;
        v.exp.is_store  = is_store;
        v.exp.imm20     = imm;
        v.exp.rd_idx    = rd;
        v.exp.rd_wen    = rd_wen;
        v.exp.rs1_idx   = rs1;
        v.exp.rs1_ren   = rs1_ren;
        v.exp.rs2_idx   = rs2;
        v.exp.rs2_ren   = rs2_ren;
        v.exp.ismv      = ismv;
        v.exp.isnop     = isnop;
        if (n_vectors < NUM_ENTRIES) begin
            vectors[n_vectors] = v;
        end
        n_vectors++;
    endtask

    // inst, unknown, unit, uop, dispatch, issue, use_imm, store, imm,
    // rd/wen, rs1/ren, rs2/ren, ismv, isnop
    task automatic fill_vectors();
        n_vectors = 0;
        add_entry(32'h002081B3, 0, exec_alu, alu_add, int_block, alu_iq, 0, 0, 20'h00000,
                  3, 1, 1, 1, 2, 1, 0, 0);
        add_entry(32'h407302B3, 0, exec_alu, alu_sub, int_block, alu_iq, 0, 0, 20'h00000,
                  5, 1, 6, 1, 7, 1, 0, 0);
        add_entry(32'hFFB58513, 0, exec_alu, alu_add, int_block, alu_iq, 1, 0, 20'hFFFFB,
                  10, 1, 11, 1, 0, 0, 0, 0);
        // addi x4, x9, 0 and add x8, x12, x0 are moves
        add_entry(32'h00048213, 0, exec_alu, alu_add, int_block, alu_iq, 1, 0, 20'h00000,
                  4, 1, 9, 1, 0, 0, 1, 0);
        add_entry(32'h00060433, 0, exec_alu, alu_add, int_block, alu_iq, 0, 0, 20'h00000,
                  8, 1, 12, 1, 0, 0, 1, 0);
        add_entry(32'h00708013, 0, exec_alu, alu_add, int_block, alu_iq, 1, 0, 20'h00007,
                  0, 0, 1, 1, 0, 0, 0, 1);
        // 6-bit shamt of 35
        add_entry(32'h02339313, 0, exec_alu, alu_sll, int_block, alu_iq, 1, 0, 20'h00023,
                  6, 1, 7, 1, 0, 0, 0, 0);
        add_entry(32'h40475693, 0, exec_alu, alu_sra, int_block, alu_iq, 1, 0, 20'h00004,
                  13, 1, 14, 1, 0, 0, 0, 0);
        add_entry(32'h4039D91B, 0, exec_alu, alu_sraw, int_block, alu_iq, 1, 0, 20'h00003,
                  18, 1, 19, 1, 0, 0, 0, 0);
        add_entry(32'h003140B3, 0, exec_alu, alu_xor, int_block, alu_iq, 0, 0, 20'h00000,
                  1, 1, 2, 1, 3, 1, 0, 0);
        // u-type: rs fields are just immediate bits
        add_entry(32'hABCDEB37, 0, exec_alu, alu_lui, int_block, alu_iq, 1, 0, 20'hABCDE,
                  22, 1, 27, 0, 28, 0, 0, 0);
        add_entry(32'hFFFFFB97, 0, exec_bru, bru_auipc, int_block, bru_iq, 1, 0, 20'hFFFFF,
                  23, 1, 31, 0, 31, 0, 0, 0);
        add_entry(32'hFF9FF0EF, 0, exec_bru, bru_jal, int_block, bru_iq, 1, 0, 20'hFFFF8,
                  1, 1, 0, 0, 0, 0, 0, 0);
        add_entry(32'hFF0302E7, 0, exec_bru, bru_jalr, int_block, bru_iq, 1, 0, 20'hFFFF0,
                  5, 1, 6, 1, 0, 0, 0, 0);
        add_entry(32'hFE209EE3, 0, exec_bru, bru_bne, int_block, bru_iq, 1, 0, 20'hFFFFC,
                  29, 0, 1, 1, 2, 1, 0, 0);
        add_entry(32'h01843383, 0, exec_none, 0, mem_block, bru_iq, 0, 0, 20'h00018,
                  7, 1, 8, 1, 24, 0, 0, 0);
        add_entry(32'hFE953C23, 0, exec_none, 0, mem_block, bru_iq, 0, 1, 20'hFFFF8,
                  24, 0, 10, 1, 9, 1, 0, 0);
        add_entry(32'h02D605BB, 0, exec_mdu, mdu_mulw, int_block, mdu_iq, 0, 0, 20'h00000,
                  11, 1, 12, 1, 13, 1, 0, 0);
        add_entry(32'h0307F733, 0, exec_mdu, mdu_remu, int_block, mdu_iq, 0, 0, 20'h00000,
                  14, 1, 15, 1, 16, 1, 0, 0);
        // csr address above the rs1 or zimm field
        add_entry(32'h300312F3, 0, exec_none, 0, int_block, bru_iq, 0, 0, 20'h06006,
                  5, 1, 6, 1, 0, 0, 0, 0);
        add_entry(32'h3412E3F3, 0, exec_none, 0, int_block, bru_iq, 0, 0, 20'h06825,
                  7, 1, 5, 0, 1, 0, 0, 0);
        // fadd.s, amoadd.w, c.addi
        add_entry(32'h003100D3, 1, exec_none, 0, unknown_block, bru_iq, 0, 0, 20'h00000,
                  1, 0, 2, 0, 3, 0, 0, 0);
        add_entry(32'h0021A0AF, 1, exec_none, 0, unknown_block, bru_iq, 0, 0, 20'h00000,
                  1, 0, 3, 0, 2, 0, 0, 0);
        add_entry(32'h00000505, 1, exec_none, 0, unknown_block, bru_iq, 0, 0, 20'h00000,
                  10, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "decode output mismatch");
        end
    endtask

    task automatic check_entry(input int n);
        vector_t v;
        string   tag;
        v   = vectors[n];
        tag = $sformatf("entry %0d (%h)", n, v.inst);
        check_value(out_valid, 1, {tag, " o_valid"});
        check_value(unknown_inst, v.unk, {tag, " unknown flag"});
        check_value(decinfo.exec_unit, v.exp.exec_unit, {tag, " exec_unit"});
        check_value(decinfo.micro_op, v.exp.micro_op, {tag, " micro_op"});
        check_value(decinfo.disp_que, v.exp.disp_que, {tag, " disp_que"});
        check_value(decinfo.issue_que, v.exp.issue_que, {tag, " issue_que"});
        check_value(decinfo.use_imm, v.exp.use_imm, {tag, " use_imm"});
        check_value(decinfo.is_store, v.exp.is_store, {tag, " is_store"});
        check_value(decinfo.imm20, v.exp.imm20, {tag, " imm20"});
        check_value(decinfo.rd_idx, v.exp.rd_idx, {tag, " rd_idx"});
        check_value(decinfo.rd_wen, v.exp.rd_wen, {tag, " rd_wen"});
        check_value(decinfo.rs1_idx, v.exp.rs1_idx, {tag, " rs1_idx"});
        check_value(decinfo.rs1_ren, v.exp.rs1_ren, {tag, " rs1_ren"});
        check_value(decinfo.rs2_idx, v.exp.rs2_idx, {tag, " rs2_idx"});
        check_value(decinfo.rs2_ren, v.exp.rs2_ren, {tag, " rs2_ren"});
        check_value(decinfo.ismv, v.exp.ismv, {tag, " ismv"});
        check_value(decinfo.isnop, v.exp.isnop, {tag, " isnop"});
    endtask

    initial begin
        vector_t held;
        rst_n = 1'b0;
        valid = 1'b0;
        inst  = '0;
        fill_vectors();
        if (n_vectors != NUM_ENTRIES) begin
            $display("vector table holds %0d entries, expected %0d", n_vectors, NUM_ENTRIES);
            $display("TESTS FAILED");
            $fatal(1, "bad vector table");
        end

        // a valid instruction during reset must not show up
        repeat (RST_CYCLES) begin
            @(posedge clk);
            valid <= 1'b1;
            inst  <= 32'h00000013;
            @(negedge clk);
            check_value(out_valid, 0, "o_valid during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        valid <= 1'b0;
        @(negedge clk);
        check_value(out_valid, 0, "o_valid in last reset cycle");

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk);
            valid <= 1'b1;
            inst  <= vectors[i].inst;
            @(negedge clk);
            check_value(out_valid, 0, $sformatf("o_valid before entry %0d is sampled", i));
            // cleared by reset before the first entry, then the previous record
            if (i == 0) begin
                held = '0;
            end else begin
                held = vectors[i - 1];
            end
            check_value(decinfo === held.exp, 1,
                        $sformatf("record held before entry %0d", i));
            check_value(unknown_inst, held.unk,
                        $sformatf("unknown flag held before entry %0d", i));
            // junk word while idle, the record should hold
            @(posedge clk);
            valid <= 1'b0;
            inst  <= 32'hFFFF_FFFF;
            @(negedge clk);
            check_entry(i);
        end

        @(posedge clk);
        @(negedge clk);
        check_value(out_valid, 0, "o_valid after last entry");
        check_value(decinfo === vectors[NUM_ENTRIES - 1].exp, 1,
                    "record held after last entry");
        check_value(unknown_inst, vectors[NUM_ENTRIES - 1].unk,
                    "unknown flag held after last entry");

        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the decode test did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic o_clk
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  wire        clk,
    input  wire        i_rst_n,
    input  wire        i_valid,
    input  wire inst_t i_inst,
    output logic       o_valid,
    output dec_info_t  o_decinfo,
    output logic       o_unknown_inst
);

    inst_class_t    cls;
    imm20_t         imm;
    wire dec_info_t dec;

    inst_classifier u_classifier (
        .i_inst  (i_inst),
        .o_class (cls)
    );

    imm_gen u_imm_gen (
        .i_inst  (i_inst),
        .i_class (cls),
        .o_imm   (imm)
    );

    uop_select u_uop_select (
        .i_class     (cls),
        .o_exec_unit (dec.exec_unit),
        .o_micro_op  (dec.micro_op),
        .o_disp_que  (dec.disp_que),
        .o_issue_que (dec.issue_que),
        .o_use_imm   (dec.use_imm),
        .o_is_store  (dec.is_store)
    );

    reg_use u_reg_use (
        .i_inst    (i_inst),
        .i_class   (cls),
        .i_imm     (imm),
        .o_rd_idx  (dec.rd_idx),
        .o_rs1_idx (dec.rs1_idx),
        .o_rs2_idx (dec.rs2_idx),
        .o_rd_wen  (dec.rd_wen),
        .o_rs1_ren (dec.rs1_ren),
        .o_rs2_ren (dec.rs2_ren),
        .o_ismv    (dec.ismv),
        .o_isnop   (dec.isnop)
    );

    assign dec.imm20 = imm;

    // record only loads with a valid instruction, holds otherwise
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid        <= 1'b0;
            o_decinfo      <= '0;
            o_unknown_inst <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_decinfo      <= dec;
                o_unknown_inst <= cls.unknown;
            end
        end
    end

    a_no_valid_after_rst: assert property (@(posedge clk) !i_rst_n |=> !o_valid)
        else $error("o_valid high in the cycle after reset");

endmodule

`default_nettype wire

// ==== reg_use.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_use
    import decode_pkg::*;
(
    input  wire inst_t       i_inst,
    input  wire inst_class_t i_class,
    input  wire imm20_t      i_imm,
    output reg_idx_t         o_rd_idx,
    output reg_idx_t         o_rs1_idx,
    output reg_idx_t         o_rs2_idx,
    output logic             o_rd_wen,
    output logic             o_rs1_ren,
    output logic             o_rs2_ren,
    output logic             o_ismv,
    output logic             o_isnop
);

    reg_idx_t rs1_raw;
    reg_idx_t rs2_raw;
    logic     int_math;
    logic     is_add;
    logic     writes_rd;
    logic     reads_rs1;
    logic     reads_rs2;

    assign rs1_raw  = i_inst[19:15];
    assign rs2_raw  = i_inst[24:20];
    assign int_math = i_class.reg_math | i_class.imm_math;
    assign is_add   = !i_class.word_op && (i_class.funct3 == 3'b000);

    assign o_rd_idx  = i_inst[11:7];
    // jal has no rs1, immediate forms and jumps have no rs2
    assign o_rs1_idx = i_class.jal ? '0 : rs1_raw;
    assign o_rs2_idx = (i_class.imm_math | i_class.jal | i_class.jalr) ? '0 : rs2_raw;

    assign writes_rd = i_class.lui | i_class.auipc | i_class.jal | i_class.jalr |
                       int_math | i_class.mul | i_class.div | i_class.csr | i_class.load;
    // csrr*i hold a zimm in the rs1 field
    assign reads_rs1 = i_class.jalr | i_class.cond_branch | i_class.load | i_class.store |
                       int_math | i_class.mul | i_class.div |
                       (i_class.csr & !i_class.funct3[2]);
    assign reads_rs2 = i_class.cond_branch | i_class.store | i_class.reg_math |
                       i_class.mul | i_class.div;

    // x0 is never read or written
    assign o_rd_wen  = writes_rd & (o_rd_idx != '0);
    assign o_rs1_ren = reads_rs1 & (o_rs1_idx != '0);
    assign o_rs2_ren = reads_rs2 & (o_rs2_idx != '0);

    // addi rd, rs, 0 or add rd, rs, x0
    assign o_ismv = (i_class.imm_math && is_add && (i_imm == '0)) ||
                    (i_class.reg_math && is_add && (i_class.funct7 == 7'b0000000) &&
                     (rs2_raw == '0));
    assign o_isnop = int_math & (o_rd_idx == '0);

endmodule

`default_nettype wire

// ==== uop_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module uop_select
    import decode_pkg::*;
(
    input  wire inst_class_t i_class,
    output exec_unit_e       o_exec_unit,
    output micro_op_t        o_micro_op,
    output disp_que_e        o_disp_que,
    output issue_que_e       o_issue_que,
    output logic             o_use_imm,
    output logic             o_is_store
);

    alu_op_e alu_op;
    bru_op_e bru_op;
    mdu_op_e mdu_op;
    logic    word;
    logic    alt;

    assign word = i_class.word_op;
    // funct7 bit 5 picks sub and sra, only for register sub
    assign alt  = i_class.funct7[5];

    always_comb begin
        alu_op = alu_none;
        if (i_class.lui) begin
            alu_op = alu_lui;
        end else if (i_class.reg_math | i_class.imm_math) begin
            case (i_class.funct3)
                3'b000: begin
                    if (i_class.reg_math && alt) begin
                        alu_op = word ? alu_subw : alu_sub;
                    end else begin
                        alu_op = word ? alu_addw : alu_add;
                    end
                end
                3'b001:  alu_op = word ? alu_sllw : alu_sll;
                3'b101: begin
                    if (alt) begin
                        alu_op = word ? alu_sraw : alu_sra;
                    end else begin
                        alu_op = word ? alu_srlw : alu_srl;
                    end
                end
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        bru_op = bru_none;
        if (i_class.auipc) begin
            bru_op = bru_auipc;
        end else if (i_class.jal) begin
            bru_op = bru_jal;
        end else if (i_class.jalr) begin
            bru_op = bru_jalr;
        end else if (i_class.cond_branch) begin
            case (i_class.funct3)
                3'b000:  bru_op = bru_beq;
                3'b001:  bru_op = bru_bne;
                3'b100:  bru_op = bru_blt;
                3'b101:  bru_op = bru_bge;
                3'b110:  bru_op = bru_bltu;
                default: bru_op = bru_bgeu;
            endcase
        end
    end

    always_comb begin
        mdu_op = mdu_none;
        if (i_class.mul) begin
            case (i_class.funct3[1:0])
                2'b00:   mdu_op = word ? mdu_mulw : mdu_mul;
                2'b01:   mdu_op = mdu_mulh;
                2'b10:   mdu_op = mdu_mulhsu;
                default: mdu_op = mdu_mulhu;
            endcase
        end else if (i_class.div) begin
            case (i_class.funct3[1:0])
                2'b00:   mdu_op = word ? mdu_divw : mdu_div;
                2'b01:   mdu_op = word ? mdu_divuw : mdu_divu;
                2'b10:   mdu_op = word ? mdu_remw : mdu_rem;
                default: mdu_op = word ? mdu_remuw : mdu_remu;
            endcase
        end
    end

    // alu wins over bru, bru over mdu
    always_comb begin
        if (alu_op != alu_none) begin
            o_exec_unit = exec_alu;
            o_micro_op  = alu_op;
        end else if (bru_op != bru_none) begin
            o_exec_unit = exec_bru;
            o_micro_op  = bru_op;
        end else if (mdu_op != mdu_none) begin
            o_exec_unit = exec_mdu;
            o_micro_op  = mdu_op;
        end else begin
            o_exec_unit = exec_none;
            o_micro_op  = '0;
        end
    end

    assign o_disp_que = (i_class.load | i_class.store) ? mem_block :
                        i_class.unknown                ? unknown_block :
                                                         int_block;

    assign o_issue_que = (i_class.reg_math | i_class.imm_math | i_class.lui) ? alu_iq :
                         (i_class.mul | i_class.div)                         ? mdu_iq :
                                                                               bru_iq;

    assign o_use_imm = i_class.imm_math | i_class.cond_branch | i_class.jal |
                       i_class.jalr | i_class.auipc | i_class.lui;
    assign o_is_store = i_class.store;

    always_comb begin
        a_unit_matches_uop: assert final ((o_exec_unit == exec_none) == (o_micro_op == '0))
            else $error("execution unit and micro-op disagree");
    end

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module imm_gen
    import decode_pkg::*;
(
    input  wire inst_t       i_inst,
    input  wire inst_class_t i_class,
    output imm20_t           o_imm
);

    imm20_t i_type;
    imm20_t s_type;
    imm20_t b_type;
    imm20_t j_type;
    imm20_t u_type;
    imm20_t shift_type;
    imm20_t csr_type;

    assign i_type = {{8{i_inst[31]}}, i_inst[31:20]};
    assign s_type = {{8{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign b_type = {{8{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    // offset bit 20 does not fit in the packed form
    assign j_type = {i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    assign u_type = i_inst[31:12];
    assign shift_type = {14'd0, i_inst[25:20]};
    // csr address above the zimm field
    assign csr_type = {3'd0, i_inst[31:20], i_inst[19:15]};

    always_comb begin
        if (i_class.lui | i_class.auipc) begin
            o_imm = u_type;
        end else if (i_class.cond_branch) begin
            o_imm = b_type;
        end else if (i_class.store) begin
            o_imm = s_type;
        end else if (i_class.load | i_class.jalr) begin
            o_imm = i_type;
        end else if (i_class.imm_math) begin
            o_imm = i_class.shift_imm ? shift_type : i_type;
        end else if (i_class.jal) begin
            o_imm = j_type;
        end else if (i_class.csr) begin
            o_imm = csr_type;
        end else begin
            o_imm = '0;
        end
    end

endmodule

`default_nettype wire

// ==== inst_classifier.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_classifier
    import decode_pkg::*;
(
    input  wire inst_t   i_inst,
    output inst_class_t  o_class
);

    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_32    = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    logic [6:0]  opcode;
    funct3_t     f3;
    funct7_t     f7;
    logic        word;
    inst_class_t cls;

    // opcode bits [1:0] must be 11, so compressed words never match
    assign opcode = i_inst[6:0];
    assign f3     = i_inst[14:12];
    assign f7     = i_inst[31:25];

    always_comb begin
        cls        = '0;
        cls.funct3 = f3;
        cls.funct7 = f7;
        word       = 1'b0;
        case (opcode)
            OPC_LUI:    cls.lui   = 1'b1;
            OPC_AUIPC:  cls.auipc = 1'b1;
            OPC_JAL:    cls.jal   = 1'b1;
            OPC_JALR:   cls.jalr  = (f3 == 3'b000);
            OPC_BRANCH: cls.cond_branch = (f3 != 3'b010) && (f3 != 3'b011);
            OPC_LOAD:   cls.load  = (f3 != 3'b111);
            OPC_STORE:  cls.store = !f3[2];
            OPC_OP: begin
                if (f7 == 7'b0000001) begin
                    cls.mul = !f3[2];
                    cls.div = f3[2];
                end else begin
                    cls.reg_math = (f7 == 7'b0000000) ||
                                   ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
                end
            end
            OPC_OP_32: begin
                word = 1'b1;
                if (f7 == 7'b0000001) begin
                    cls.mul = (f3 == 3'b000);
                    cls.div = f3[2];
                end else begin
                    cls.reg_math = ((f7 == 7'b0000000) &&
                                    ((f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b101))) ||
                                   ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
                end
            end
            OPC_OP_IMM: begin
                // rv64 shifts carry a 6-bit shamt, so only funct6 is checked
                case (f3)
                    3'b001:  cls.shift_imm = (i_inst[31:26] == 6'b000000);
                    3'b101:  cls.shift_imm = (i_inst[31:26] == 6'b000000) ||
                                             (i_inst[31:26] == 6'b010000);
                    default: cls.imm_math  = 1'b1;
                endcase
                cls.imm_math = cls.imm_math | cls.shift_imm;
            end
            OPC_OP_IMM32: begin
                word = 1'b1;
                case (f3)
                    3'b000:  cls.imm_math  = 1'b1;
                    3'b001:  cls.shift_imm = (f7 == 7'b0000000);
                    3'b101:  cls.shift_imm = (f7 == 7'b0000000) || (f7 == 7'b0100000);
                    default: cls.imm_math  = 1'b0;
                endcase
                cls.imm_math = cls.imm_math | cls.shift_imm;
            end
            // funct3 000 and 100 are the privileged group, not kept
            OPC_SYSTEM: cls.csr = (f3 != 3'b000) && (f3 != 3'b100);
            default:    cls.csr = 1'b0;
        endcase

        cls.unknown = !(cls.lui | cls.auipc | cls.jal | cls.jalr | cls.cond_branch |
                        cls.load | cls.store | cls.reg_math | cls.imm_math |
                        cls.mul | cls.div | cls.csr);
        cls.word_op = word & !cls.unknown;
    end

    assign o_class = cls;

    always_comb begin
        a_class_onehot: assert final ($onehot({cls.lui, cls.auipc, cls.jal, cls.jalr,
                                               cls.cond_branch, cls.load, cls.store,
                                               cls.reg_math, cls.imm_math, cls.mul,
                                               cls.div, cls.csr, cls.unknown}))
            else $error("instruction class flags are not one-hot");
    end

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    // u-type immediates stay unshifted
    typedef logic [19:0] imm20_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  micro_op_t;

    typedef enum logic [4:0] {
        alu_none, alu_lui, alu_add, alu_sub, alu_addw, alu_subw,
        alu_sll, alu_srl, alu_sra, alu_sllw, alu_srlw, alu_sraw,
        alu_xor, alu_or, alu_and, alu_slt, alu_sltu
    } alu_op_e;

    typedef enum logic [4:0] {
        bru_none, bru_auipc, bru_jal, bru_jalr,
        bru_beq, bru_bne, bru_blt, bru_bge, bru_bltu, bru_bgeu
    } bru_op_e;

    // divuw appended after the rest so the other codes keep their values
    typedef enum logic [4:0] {
        mdu_none, mdu_mul, mdu_mulw, mdu_mulh, mdu_mulhu, mdu_mulhsu,
        mdu_div, mdu_divw, mdu_divu, mdu_rem, mdu_remw, mdu_remu, mdu_remuw,
        mdu_divuw
    } mdu_op_e;

    typedef enum logic [1:0] {
        exec_none, exec_alu, exec_bru, exec_mdu
    } exec_unit_e;

    typedef enum logic [1:0] {
        int_block, mem_block, unknown_block
    } disp_que_e;

    typedef enum logic [1:0] {
        alu_iq, mdu_iq, bru_iq
    } issue_que_e;

    typedef struct packed {
        logic    lui;
        logic    auipc;
        logic    jal;
        logic    jalr;
        logic    cond_branch;
        logic    load;
        logic    store;
        logic    reg_math;
        logic    imm_math;
        // modifiers, set together with reg_math or imm_math
        logic    shift_imm;
        logic    word_op;
        logic    mul;
        logic    div;
        logic    csr;
        logic    unknown;
        funct3_t funct3;
        funct7_t funct7;
    } inst_class_t;

    typedef struct packed {
        logic       ismv;
        logic       isnop;
        imm20_t     imm20;
        logic       use_imm;
        logic       rd_wen;
        reg_idx_t   rd_idx;
        reg_idx_t   rs1_idx;
        reg_idx_t   rs2_idx;
        logic       rs1_ren;
        logic       rs2_ren;
        exec_unit_e exec_unit;
        micro_op_t  micro_op;
        disp_que_e  disp_que;
        issue_que_e issue_que;
        logic       is_store;
    } dec_info_t;

endpackage

`default_nettype wire
